/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = iigs_io_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '** FAIL **' $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/iigs_adb.sv */
`default_nettype none

module iigs_adb (
  input  wire                  clk_sys,
  input  wire                  cpu_vda,
  periph_if.dev                bus,
  input  wire                  key_valid,
  input  wire iigs_pkg::data_t key_code
);

  logic [6:0]      key_latch;
  logic            key_strobe;  // bit 7 of $c000
  iigs_pkg::data_t cmd_q;
  logic            cmd_full;
  logic [3:0]      mod_q;       // modifier keys
  iigs_pkg::data_t status;
  iigs_pkg::data_t rd_data;

  assign status = {key_strobe, cmd_full, 2'b00, mod_q};

  always_comb begin
    case (bus.addr)
      iigs_pkg::OFS_KBD,
      iigs_pkg::OFS_KBDSTRB:  rd_data = {key_strobe, key_latch};
      iigs_pkg::OFS_ADB_CMD:  rd_data = cmd_q;
      iigs_pkg::OFS_ADB_STAT: rd_data = status;
      default:                rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      key_latch  <= '0;
      key_strobe <= 1'b0;
      cmd_q      <= '0;
      cmd_full   <= 1'b0;
      mod_q      <= '0;
    end else begin
      if (key_valid) begin
        key_latch  <= key_code[6:0];
        key_strobe <= 1'b1;
      end
      if (bus.strobe) begin
        case (bus.addr)
          iigs_pkg::OFS_KBDSTRB: key_strobe <= 1'b0;  // any access clears
          iigs_pkg::OFS_ADB_HOOK:
            if (!bus.rw) begin
              key_latch  <= bus.din[6:0];
              key_strobe <= 1'b1;
            end
          iigs_pkg::OFS_ADB_CMD:
            if (!bus.rw) begin
              cmd_q    <= bus.din;
              cmd_full <= 1'b1;
            end
          iigs_pkg::OFS_ADB_STAT:
            if (!bus.rw)
              mod_q <= bus.din[3:0];
            else
              cmd_full <= 1'b0;  // status read takes the command
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (bus.strobe && bus.rw)
      bus.dout <= rd_data;
  end

endmodule

`default_nettype wire

/* design/iigs_io.sv */
`default_nettype none

module iigs_io #(
  parameter int TICKS_PER_SEC = 1000
) (
  input  wire                    clk_sys,
  input  wire                    cpu_vda,
  input  wire                    cen,
  input  wire                    bus_valid,
  input  wire                    bus_we,
  input  wire iigs_pkg::bank_t   bus_bank,
  input  wire iigs_pkg::addr16_t bus_addr,
  input  wire iigs_pkg::data_t   bus_wdata,
  input  wire iigs_pkg::data_t   mem_din,
  output iigs_pkg::data_t        cpu_din,
  output logic                   io_ack,
  output iigs_pkg::data_t        shadow,
  output iigs_pkg::data_t        text_color,
  output logic [3:0]             border_color,
  output iigs_pkg::data_t        slt_rom_sel,
  output iigs_pkg::data_t        disk35
);

  periph_if adb_if ();
  periph_if prtc_if ();
  periph_if iwm_if ();

  iigs_io_regs i_iigs_io_regs (
    .clk_sys      (clk_sys),
    .cpu_vda      (cpu_vda),
    .bus_valid    (bus_valid),
    .bus_we       (bus_we),
    .bus_bank     (bus_bank),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .mem_din      (mem_din),
    .cpu_din      (cpu_din),
    .io_ack       (io_ack),
    .shadow       (shadow),
    .text_color   (text_color),
    .border_color (border_color),
    .slt_rom_sel  (slt_rom_sel),
    .disk35       (disk35),
    .adb          (adb_if),
    .prtc         (prtc_if),
    .iwm          (iwm_if)
  );

  // no keyboard source yet so $c070 loads the latch
  iigs_adb i_iigs_adb (
    .clk_sys   (clk_sys),
    .cpu_vda   (cpu_vda),
    .bus       (adb_if),
    .key_valid (1'b0),
    .key_code  (8'h00)
  );

  iigs_prtc #(
    .TICKS_PER_SEC (TICKS_PER_SEC)
  ) i_iigs_prtc (
    .clk_sys (clk_sys),
    .cpu_vda (cpu_vda),
    .cen     (cen),
    .bus     (prtc_if)
  );

  iigs_iwm i_iigs_iwm (
    .clk_sys (clk_sys),
    .cpu_vda (cpu_vda),
    .bus     (iwm_if),
    .disk35  (disk35)
  );

endmodule

`default_nettype wire

/* design/iigs_io_regs.sv */
`default_nettype none

module iigs_io_regs (
  input  wire                       clk_sys,
  input  wire                       cpu_vda,
  input  wire                       bus_valid,
  input  wire                       bus_we,
  input  wire iigs_pkg::bank_t      bus_bank,
  input  wire iigs_pkg::addr16_t    bus_addr,
  input  wire iigs_pkg::data_t      bus_wdata,
  input  wire iigs_pkg::data_t      mem_din,
  output iigs_pkg::data_t           cpu_din,
  output logic                      io_ack,
  output iigs_pkg::data_t           shadow,
  output iigs_pkg::data_t           text_color,
  output logic [3:0]                border_color,
  output iigs_pkg::data_t           slt_rom_sel,
  output iigs_pkg::data_t           disk35,
  periph_if.host                    adb,
  periph_if.host                    prtc,
  periph_if.host                    iwm
);

  iigs_pkg::reg_ofs_t ofs;
  logic               bank_ok;
  logic               io_hit;
  iigs_pkg::periph_e  sel;
  iigs_pkg::periph_e  src_q;
  iigs_pkg::data_t    rd_data;
  iigs_pkg::data_t    io_dout_q;
  iigs_pkg::reg_ofs_t req_ofs;
  iigs_pkg::data_t    req_din;
  logic               req_rw;
  iigs_pkg::data_t    state_reg;

  iigs_pkg::data_t wvideo, cyareg;
  iigs_pkg::data_t sound_ctl, sound_data, sound_adr_l, sound_adr_h;

  logic eighty_store, ramrd, ramwrt, intcxrom, altzp, slotc3rom, eighty_col, altcharset;
  logic textg, mixg, page2, hires;
  logic lcram, lcram2, rombank;

  assign ofs     = bus_addr[7:0];
  assign bank_ok = bus_bank inside {8'h00, 8'h01, 8'he0, 8'he1};
  assign io_hit  = bus_valid && !shadow[6] && bank_ok &&
                   (bus_addr[15:8] == iigs_pkg::IO_PAGE_HI);

  // bit 3 reads back as the inverse of lcram
  assign state_reg = {altzp, page2, ramrd, ramwrt, lcram, lcram2, rombank, intcxrom} ^ 8'h08;

  // who answers this offset
  always_comb begin
    sel = iigs_pkg::src_local;
    case (ofs)
      iigs_pkg::OFS_KBD: if (!bus_we) sel = iigs_pkg::src_adb;  // writes toggle 80store
      iigs_pkg::OFS_KBDSTRB, iigs_pkg::OFS_ADB_CMD,
      iigs_pkg::OFS_ADB_STAT, iigs_pkg::OFS_ADB_HOOK: sel = iigs_pkg::src_adb;
      iigs_pkg::OFS_CLK_DATA, iigs_pkg::OFS_CLK_CTL:  sel = iigs_pkg::src_prtc;
      default: if (ofs[7:4] == 4'he) sel = iigs_pkg::src_iwm;
    endcase
  end

  // local read mux with status flags in bit 7
  always_comb begin
    rd_data = '0;
    case (ofs)
      8'h11: rd_data = {lcram2, 7'b0};
      8'h12: rd_data = {lcram, 7'b0};
      8'h13: rd_data = {ramrd, 7'b0};
      8'h14: rd_data = {ramwrt, 7'b0};
      8'h15: rd_data = {intcxrom, 7'b0};
      8'h16: rd_data = {altzp, 7'b0};
      8'h17: rd_data = {slotc3rom, 7'b0};
      8'h18: rd_data = {eighty_store, 7'b0};
      8'h1a: rd_data = {textg, 7'b0};
      8'h1b: rd_data = {mixg, 7'b0};
      8'h1c: rd_data = {page2, 7'b0};
      8'h1d: rd_data = {hires, 7'b0};
      8'h1e: rd_data = {altcharset, 7'b0};
      8'h1f: rd_data = {eighty_col, 7'b0};
      iigs_pkg::OFS_TEXTCOLOR: rd_data = text_color;
      iigs_pkg::OFS_NEWVIDEO:  rd_data = wvideo;
      iigs_pkg::OFS_SLTROMSEL: rd_data = slt_rom_sel;
      iigs_pkg::OFS_DISK35:    rd_data = disk35;
      iigs_pkg::OFS_SHADOW:    rd_data = shadow;
      iigs_pkg::OFS_CYAREG:    rd_data = cyareg;
      iigs_pkg::OFS_SND_CTL:   rd_data = sound_ctl;
      iigs_pkg::OFS_SND_DATA:  rd_data = sound_data;
      iigs_pkg::OFS_SND_ADR_L: rd_data = sound_adr_l;
      iigs_pkg::OFS_SND_ADR_H: rd_data = sound_adr_h;
      iigs_pkg::OFS_STATEREG:  rd_data = state_reg;
      default: ;
    endcase
  end

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      io_ack       <= 1'b0;
      src_q        <= iigs_pkg::src_none;
      adb.strobe   <= 1'b0;
      prtc.strobe  <= 1'b0;
      iwm.strobe   <= 1'b0;
      shadow       <= iigs_pkg::SHADOW_RST;
      cyareg       <= iigs_pkg::CYAREG_RST;
      text_color   <= '0;
      border_color <= '0;
      slt_rom_sel  <= '0;
      disk35       <= '0;
      wvideo       <= '0;
      sound_ctl    <= '0;
      sound_data   <= '0;
      sound_adr_l  <= '0;
      sound_adr_h  <= '0;
      {eighty_store, eighty_col, altcharset, slotc3rom} <= '0;
      {textg, mixg, hires} <= '0;
      {altzp, page2, ramrd, ramwrt, lcram, lcram2, rombank, intcxrom} <=
        iigs_pkg::STATEREG_RST;
    end else begin
      io_ack      <= (io_hit && sel == iigs_pkg::src_local) ||
                     adb.strobe || prtc.strobe || iwm.strobe;
      adb.strobe  <= io_hit && sel == iigs_pkg::src_adb;
      prtc.strobe <= io_hit && sel == iigs_pkg::src_prtc;
      iwm.strobe  <= io_hit && sel == iigs_pkg::src_iwm;

      if (io_hit)
        src_q <= sel;
      else if (io_ack)
        src_q <= iigs_pkg::src_none;  // answer delivered

      if (io_hit && bus_we) begin
        case (ofs)
          iigs_pkg::OFS_TEXTCOLOR: text_color   <= bus_wdata;
          iigs_pkg::OFS_NEWVIDEO:  wvideo       <= bus_wdata;
          iigs_pkg::OFS_SLTROMSEL: slt_rom_sel  <= bus_wdata;
          iigs_pkg::OFS_DISK35:    disk35       <= bus_wdata & 8'hc0;
          iigs_pkg::OFS_CLK_CTL:   border_color <= bus_wdata[3:0];  // clock chip sees it too
          iigs_pkg::OFS_SHADOW:    shadow       <= bus_wdata;
          iigs_pkg::OFS_CYAREG:    cyareg       <= bus_wdata;
          iigs_pkg::OFS_SND_CTL:   sound_ctl    <= bus_wdata;
          iigs_pkg::OFS_SND_DATA:  sound_data   <= bus_wdata;
          iigs_pkg::OFS_SND_ADR_L: sound_adr_l  <= bus_wdata;
          iigs_pkg::OFS_SND_ADR_H: sound_adr_h  <= bus_wdata;
          iigs_pkg::OFS_STATEREG:
            {altzp, page2, ramrd, ramwrt, lcram, lcram2, rombank, intcxrom} <=
              bus_wdata ^ 8'h08;
          default: ;
        endcase

        // even offset clears, odd offset sets
        if (ofs[7:4] == 4'h0) begin
          case (ofs[3:1])
            3'd0: eighty_store <= ofs[0];
            3'd1: ramrd        <= ofs[0];
            3'd2: ramwrt       <= ofs[0];
            3'd3: intcxrom     <= ofs[0];
            3'd4: altzp        <= ofs[0];
            3'd5: slotc3rom    <= ofs[0];
            3'd6: eighty_col   <= ofs[0];
            3'd7: altcharset   <= ofs[0];
          endcase
        end
      end

      // video switches react to reads as well
      if (io_hit && ofs[7:3] == 5'b0101_0) begin
        case (ofs[2:1])
          2'd0: textg <= ofs[0];
          2'd1: mixg  <= ofs[0];
          2'd2: page2 <= ofs[0];
          2'd3: hires <= ofs[0];
        endcase
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (io_hit) begin
      io_dout_q <= rd_data;
      req_ofs   <= ofs;
      req_din   <= bus_wdata;
      req_rw    <= !bus_we;
    end
  end

  assign adb.addr  = req_ofs;
  assign adb.din   = req_din;
  assign adb.rw    = req_rw;
  assign prtc.addr = req_ofs;
  assign prtc.din  = req_din;
  assign prtc.rw   = req_rw;
  assign iwm.addr  = req_ofs;
  assign iwm.din   = req_din;
  assign iwm.rw    = req_rw;

  always_comb begin
    cpu_din = mem_din;
    if (io_ack) begin
      case (src_q)
        iigs_pkg::src_local: cpu_din = io_dout_q;
        iigs_pkg::src_adb:   cpu_din = adb.dout;
        iigs_pkg::src_prtc:  cpu_din = prtc.dout;
        iigs_pkg::src_iwm:   cpu_din = iwm.dout;
        default:             cpu_din = mem_din;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/iigs_iwm.sv */
`default_nettype none

module iigs_iwm (
  input  wire                  clk_sys,
  input  wire                  cpu_vda,
  periph_if.dev                bus,
  input  wire iigs_pkg::data_t disk35
);

  // ph0..ph3, motor, drive select, q6, q7
  logic [7:0]      sw_q;
  logic [7:0]      sw_next;
  logic [4:0]      mode_q;
  logic            motor_on;
  logic            q6, q7;
  iigs_pkg::data_t rd_data;

  always_comb begin
    sw_next = sw_q;
    sw_next[bus.addr[3:1]] = bus.addr[0];  // odd address sets
  end

  assign q6       = sw_next[6];
  assign q7       = sw_next[7];
  assign motor_on = sw_next[4] & disk35[6];

  assign rd_data = (q6 && !q7) ? {2'b00, motor_on, mode_q} : 8'hff;

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      sw_q   <= '0;
      mode_q <= '0;
    end else if (bus.strobe) begin
      sw_q <= sw_next;
      if (!bus.rw && q6 && q7)
        mode_q <= bus.din[4:0];  // mode load
    end
  end

  always_ff @(posedge clk_sys) begin
    if (bus.strobe && bus.rw)
      bus.dout <= rd_data;
  end

endmodule

`default_nettype wire

/* design/iigs_pkg.sv */
`default_nettype none

package iigs_pkg;

  typedef logic [7:0]  bank_t;     // cpu bank number
  typedef logic [15:0] addr16_t;   // address within a bank
  typedef logic [7:0]  data_t;
  typedef logic [7:0]  reg_ofs_t;  // offset within the $c0xx page

  // source that answers the pending read
  typedef enum logic [2:0] {
    src_none,
    src_local,
    src_adb,
    src_prtc,
    src_iwm
  } periph_e;

  // clock chip sequencer
  typedef enum logic [1:0] {
    st_idle,
    st_cmd,
    st_data,
    st_done
  } prtc_state_e;

  localparam data_t IO_PAGE_HI = 8'hc0;

  localparam data_t SHADOW_RST   = 8'b0000_1000;
  localparam data_t STATEREG_RST = 8'b0000_1001;
  localparam data_t CYAREG_RST   = 8'h80;  // fast mode

  localparam reg_ofs_t OFS_KBD       = 8'h00;
  localparam reg_ofs_t OFS_KBDSTRB   = 8'h10;
  localparam reg_ofs_t OFS_TEXTCOLOR = 8'h22;
  localparam reg_ofs_t OFS_ADB_CMD   = 8'h26;
  localparam reg_ofs_t OFS_ADB_STAT  = 8'h27;
  localparam reg_ofs_t OFS_NEWVIDEO  = 8'h29;
  localparam reg_ofs_t OFS_SLTROMSEL = 8'h2d;
  localparam reg_ofs_t OFS_DISK35    = 8'h31;
  localparam reg_ofs_t OFS_CLK_DATA  = 8'h33;
  localparam reg_ofs_t OFS_CLK_CTL   = 8'h34;  // shared with border color
  localparam reg_ofs_t OFS_SHADOW    = 8'h35;
  localparam reg_ofs_t OFS_CYAREG    = 8'h36;
  localparam reg_ofs_t OFS_SND_CTL   = 8'h3c;
  localparam reg_ofs_t OFS_SND_DATA  = 8'h3d;
  localparam reg_ofs_t OFS_SND_ADR_L = 8'h3e;
  localparam reg_ofs_t OFS_SND_ADR_H = 8'h3f;
  localparam reg_ofs_t OFS_STATEREG  = 8'h68;
  localparam reg_ofs_t OFS_ADB_HOOK  = 8'h70;

endpackage

`default_nettype wire

/* design/iigs_prtc.sv */
`default_nettype none

module iigs_prtc #(
  parameter int TICKS_PER_SEC = 1000
) (
  input  wire   clk_sys,
  input  wire   cpu_vda,
  input  wire   cen,
  periph_if.dev bus
);

  localparam int TW = $clog2(TICKS_PER_SEC + 1);

  logic [TW-1:0]         tick_q;
  iigs_pkg::data_t       sec_q;
  iigs_pkg::data_t       ctl_q;     // bit 7 start
  iigs_pkg::data_t       data_q;
  iigs_pkg::data_t       bram [32];
  iigs_pkg::prtc_state_e state_q;
  logic                  have_cmd;  // next start moves data
  logic                  cmd_rd;
  logic [4:0]            cmd_addr;
  logic                  sec_sel;
  logic                  start_wr;
  iigs_pkg::data_t       rd_data;

  assign sec_sel  = (cmd_addr == 5'd31);
  assign start_wr = bus.strobe && !bus.rw && bus.din[7] &&
                    (bus.addr == iigs_pkg::OFS_CLK_CTL);
  assign rd_data  = (bus.addr == iigs_pkg::OFS_CLK_DATA) ? data_q : ctl_q;

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      tick_q   <= '0;
      sec_q    <= '0;
      ctl_q    <= '0;
      data_q   <= '0;
      state_q  <= iigs_pkg::st_idle;
      have_cmd <= 1'b0;
      cmd_rd   <= 1'b0;
      cmd_addr <= '0;
    end else begin
      if (cen) begin
        if (tick_q == TW'(TICKS_PER_SEC - 1)) begin
          tick_q <= '0;
          sec_q  <= sec_q + 8'd1;
        end else begin
          tick_q <= tick_q + 1'b1;
        end
      end

      if (bus.strobe && !bus.rw) begin
        if (bus.addr == iigs_pkg::OFS_CLK_DATA)
          data_q <= bus.din;
        else if (bus.addr == iigs_pkg::OFS_CLK_CTL)
          ctl_q <= bus.din;
      end

      case (state_q)
        iigs_pkg::st_idle:
          if (start_wr)
            state_q <= have_cmd ? iigs_pkg::st_data : iigs_pkg::st_cmd;
        iigs_pkg::st_cmd: begin
          cmd_rd   <= data_q[7];
          cmd_addr <= data_q[6:2];
          have_cmd <= 1'b1;
          state_q  <= iigs_pkg::st_done;
        end
        iigs_pkg::st_data: begin
          if (cmd_rd)
            data_q <= sec_sel ? sec_q : bram[cmd_addr];
          else if (sec_sel)
            sec_q <= data_q;  // set the clock
          have_cmd <= 1'b0;
          state_q  <= iigs_pkg::st_done;
        end
        iigs_pkg::st_done: begin
          // a start that lands here begins the next phase at once
          if (start_wr) begin
            state_q <= have_cmd ? iigs_pkg::st_data : iigs_pkg::st_cmd;
          end else begin
            ctl_q[7] <= 1'b0;
            state_q  <= iigs_pkg::st_idle;
          end
        end
        default: state_q <= iigs_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (state_q == iigs_pkg::st_data && !cmd_rd && !sec_sel)
      bram[cmd_addr] <= data_q;
  end

  always_ff @(posedge clk_sys) begin
    if (bus.strobe && bus.rw)
      bus.dout <= rd_data;
  end

endmodule

`default_nettype wire

/* design/periph_if.sv */
`default_nettype none

interface periph_if;

  logic              strobe;  // one cycle per access
  logic              rw;      // high for read
  iigs_pkg::reg_ofs_t addr;
  iigs_pkg::data_t    din;
  iigs_pkg::data_t    dout;   // valid the cycle after a read strobe

  modport host (
    output strobe, rw, addr, din,
    input  dout
  );

  modport dev (
    input  strobe, rw, addr, din,
    output dout
  );

endinterface

`default_nettype wire

/* flist.f */
design/iigs_pkg.sv
design/periph_if.sv
design/iigs_io_regs.sv
design/iigs_adb.sv
design/iigs_prtc.sv
design/iigs_iwm.sv
design/iigs_io.sv
tb/iigs_io_chk.sv
tb/iigs_io_tb.sv

/* tb/iigs_io_chk.sv */
`default_nettype none

module iigs_io_chk (
  input wire                    clk_sys,
  input wire                    cpu_vda,
  input wire                    io_hit,
  input wire iigs_pkg::periph_e sel,
  input wire                    io_ack,
  input wire                    adb_strobe,
  input wire                    prtc_strobe,
  input wire                    iwm_strobe
);

  int unsigned fail_count = 0;  // failed assertions so far
  logic        any_strobe;

  assign any_strobe = adb_strobe || prtc_strobe || iwm_strobe;

  // each strobe is a single cycle pulse
  a_strobe_pulse: assert property (@(posedge clk_sys) disable iff (cpu_vda)
    any_strobe |=> !any_strobe)
    else begin
      $error("peripheral strobe held for more than one cycle");
      fail_count++;
    end

  a_local_ack: assert property (@(posedge clk_sys) disable iff (cpu_vda)
    (io_hit && sel == iigs_pkg::src_local) |=> io_ack)
    else begin
      $error("io_ack missing one cycle after a local access");
      fail_count++;
    end

  // strobe one cycle after the access and io_ack exactly one cycle after the strobe
  a_periph_ack: assert property (@(posedge clk_sys) disable iff (cpu_vda)
    (io_hit && sel != iigs_pkg::src_local) |=> (any_strobe && !io_ack) ##1 io_ack)
    else begin
      $error("peripheral access not followed by strobe and then io_ack");
      fail_count++;
    end

  a_reset_ack: assert property (@(posedge clk_sys) cpu_vda |-> !io_ack)
    else begin
      $error("io_ack high during reset");
      fail_count++;
    end

endmodule

`default_nettype wire

/* tb/iigs_io_tb.sv */
`default_nettype none

module iigs_io_tb;

  localparam int TICKS        = 16;
  localparam int ACK_TIMEOUT  = 8;   // cycles
  localparam int BUSY_TIMEOUT = 16;  // status polls

  logic              clk_sys;
  logic              cpu_vda;
  logic              cen;
  logic              bus_valid;
  logic              bus_we;
  iigs_pkg::bank_t   bus_bank;
  iigs_pkg::addr16_t bus_addr;
  iigs_pkg::data_t   bus_wdata;
  iigs_pkg::data_t   mem_din;
  iigs_pkg::data_t   cpu_din;
  logic              io_ack;
  iigs_pkg::data_t   shadow;
  iigs_pkg::data_t   text_color;
  logic [3:0]        border_color;
  iigs_pkg::data_t   slt_rom_sel;
  iigs_pkg::data_t   disk35;

  int n_checks;
  int n_errors;

  iigs_io #(
    .TICKS_PER_SEC (TICKS)
  ) i_iigs_io (
    .clk_sys      (clk_sys),
    .cpu_vda      (cpu_vda),
    .cen          (cen),
    .bus_valid    (bus_valid),
    .bus_we       (bus_we),
    .bus_bank     (bus_bank),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .mem_din      (mem_din),
    .cpu_din      (cpu_din),
    .io_ack       (io_ack),
    .shadow       (shadow),
    .text_color   (text_color),
    .border_color (border_color),
    .slt_rom_sel  (slt_rom_sel),
    .disk35       (disk35)
  );

  bind iigs_io_regs iigs_io_chk i_iigs_io_chk (
    .clk_sys     (clk_sys),
    .cpu_vda     (cpu_vda),
    .io_hit      (io_hit),
    .sel         (sel),
    .io_ack      (io_ack),
    .adb_strobe  (adb.strobe),
    .prtc_strobe (prtc.strobe),
    .iwm_strobe  (iwm.strobe)
  );

  always #10 clk_sys = ~clk_sys;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic check_data(input iigs_pkg::data_t got, input iigs_pkg::data_t exp,
                            input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_nibble(input logic [3:0] got, input logic [3:0] exp,
                              input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    $display("test %s finished with %0d errors", name, n_errors - err0);
  endtask

  task automatic apply_reset();
    bus_valid = 1'b0;
    cpu_vda   = 1'b1;
    repeat (8) @(negedge clk_sys);
    cpu_vda = 1'b0;
  endtask

  // one cycle access and a wait for io_ack
  task automatic bus_access(input iigs_pkg::bank_t bank, input iigs_pkg::addr16_t addr,
                            input logic we, input iigs_pkg::data_t wdata,
                            output iigs_pkg::data_t rdata);
    int n;
    bus_bank  = bank;
    bus_addr  = addr;
    bus_we    = we;
    bus_wdata = wdata;
    bus_valid = 1'b1;
    @(negedge clk_sys);
    bus_valid = 1'b0;
    n = 0;
    while (!io_ack && n < ACK_TIMEOUT) begin
      @(negedge clk_sys);
      n++;
    end
    if (!io_ack)
      abort_run($sformatf("timeout at %0t: no io_ack for %h:%h", $time, bank, addr));
    else
      rdata = cpu_din;
  endtask

  task automatic io_write(input iigs_pkg::reg_ofs_t ofs, input iigs_pkg::data_t d);
    iigs_pkg::data_t unused_rd;
    bus_access(8'h00, {iigs_pkg::IO_PAGE_HI, ofs}, 1'b1, d, unused_rd);
  endtask

  task automatic io_read(input iigs_pkg::reg_ofs_t ofs, output iigs_pkg::data_t d);
    bus_access(8'h00, {iigs_pkg::IO_PAGE_HI, ofs}, 1'b0, 8'h00, d);
  endtask

  // a non I/O access must pass mem_din through and give no io_ack
  task automatic check_passthrough(input iigs_pkg::bank_t bank, input string what);
    int n;
    logic ack_seen;
    ack_seen  = 1'b0;
    bus_bank  = bank;
    bus_addr  = 16'hc035;
    bus_we    = 1'b0;
    bus_valid = 1'b1;
    @(negedge clk_sys);
    check_data(cpu_din, mem_din, what);
    bus_valid = 1'b0;
    for (n = 0; n < 3; n++) begin
      if (io_ack)
        ack_seen = 1'b1;
      @(negedge clk_sys);
    end
    n_checks++;
    if (ack_seen) begin
      n_errors++;
      $display("io_ack rose on a non I/O access (%s)", what);
    end
  endtask

  // set the start bit and poll until the sequence is over
  task automatic clock_start();
    iigs_pkg::data_t ctl;
    int n;
    io_write(iigs_pkg::OFS_CLK_CTL, 8'h80);
    io_read(iigs_pkg::OFS_CLK_CTL, ctl);
    n = 0;
    while (ctl[7] && n < BUSY_TIMEOUT) begin
      io_read(iigs_pkg::OFS_CLK_CTL, ctl);
      n++;
    end
    if (ctl[7])
      abort_run("clock chip start bit never cleared");
  endtask

  // command phase then data phase
  task automatic clock_transfer(input iigs_pkg::data_t cmd, input iigs_pkg::data_t wdata,
                                output iigs_pkg::data_t rdata);
    io_write(iigs_pkg::OFS_CLK_DATA, cmd);
    clock_start();
    io_write(iigs_pkg::OFS_CLK_DATA, wdata);
    clock_start();
    io_read(iigs_pkg::OFS_CLK_DATA, rdata);
  endtask

  task automatic pulse_cen(input int count);
    for (int i = 0; i < count; i++) begin
      cen = 1'b1;
      @(negedge clk_sys);
      cen = 1'b0;
      @(negedge clk_sys);
    end
  endtask

  task automatic test_reset_values();
    iigs_pkg::data_t d;
    int err0;
    err0 = n_errors;
    io_read(iigs_pkg::OFS_SHADOW, d);
    check_data(d, iigs_pkg::SHADOW_RST, "shadow reg");
    io_read(iigs_pkg::OFS_CYAREG, d);
    check_data(d, iigs_pkg::CYAREG_RST, "speed reg");
    io_read(iigs_pkg::OFS_STATEREG, d);
    check_data(d, iigs_pkg::STATEREG_RST ^ 8'h08, "state reg");
    check_data(shadow, iigs_pkg::SHADOW_RST, "shadow port");
    report_test("reset_values", err0);
  endtask

  task automatic test_register_rw();
    iigs_pkg::reg_ofs_t regs [7];
    iigs_pkg::data_t v;
    iigs_pkg::data_t d;
    int err0;
    regs = '{8'h22, 8'h2d, 8'h3c, 8'h3d, 8'h3e, 8'h3f, 8'h29};
    err0 = n_errors;
    foreach (regs[i]) begin
      v = iigs_pkg::data_t'($urandom);
      io_write(regs[i], v);
      io_read(regs[i], d);
      check_data(d, v, $sformatf("reg c0%h", regs[i]));
      if (regs[i] == iigs_pkg::OFS_TEXTCOLOR)
        check_data(text_color, v, "text_color port");
      if (regs[i] == iigs_pkg::OFS_SLTROMSEL)
        check_data(slt_rom_sel, v, "slt_rom_sel port");
    end
    v = iigs_pkg::data_t'($urandom);
    io_write(iigs_pkg::OFS_DISK35, v);
    io_read(iigs_pkg::OFS_DISK35, d);
    check_data(d, v & 8'hc0, "disk35 reg");
    check_data(disk35, v & 8'hc0, "disk35 port");
    v = iigs_pkg::data_t'($urandom) & 8'h7f;  // start bit clear
    io_write(iigs_pkg::OFS_CLK_CTL, v);
    check_nibble(border_color, v[3:0], "border_color port");
    report_test("register_rw", err0);
  endtask

  task automatic test_soft_switches();
    iigs_pkg::data_t exp;
    iigs_pkg::data_t v;
    iigs_pkg::data_t d;
    int err0;
    err0 = n_errors;
    exp = iigs_pkg::STATEREG_RST ^ 8'h08;
    io_write(8'h03, 8'h00);  // ramrd on
    exp[5] = 1'b1;
    io_write(8'h05, 8'h00);  // ramwrt on
    exp[4] = 1'b1;
    io_write(8'h09, 8'h00);  // altzp on
    exp[7] = 1'b1;
    io_read(8'h55, d);       // page2 on by a read
    exp[6] = 1'b1;
    io_write(8'h06, 8'h00);  // intcxrom off
    exp[0] = 1'b0;
    io_read(iigs_pkg::OFS_STATEREG, d);
    check_data(d, exp, "state reg after toggles");
    v = iigs_pkg::data_t'($urandom);
    io_write(iigs_pkg::OFS_STATEREG, v);
    io_read(iigs_pkg::OFS_STATEREG, d);
    check_data(d, v, "state reg write");
    bus_access(8'he0, 16'hc036, 1'b0, 8'h00, d);
    check_data(d, iigs_pkg::CYAREG_RST, "speed reg in bank e0");
    mem_din = iigs_pkg::data_t'($urandom);
    check_passthrough(8'h02, "bank 02 read");
    io_write(iigs_pkg::OFS_SHADOW, iigs_pkg::SHADOW_RST | 8'h40);
    check_passthrough(8'h00, "read with shadow bit 6 set");
    apply_reset();           // only a reset brings the I/O page back
    report_test("soft_switches", err0);
  endtask

  task automatic test_adb();
    iigs_pkg::data_t v;
    iigs_pkg::data_t d;
    int err0;
    err0 = n_errors;
    v = iigs_pkg::data_t'($urandom);
    io_write(iigs_pkg::OFS_ADB_HOOK, v);
    io_read(iigs_pkg::OFS_KBD, d);
    check_data(d, {1'b1, v[6:0]}, "key latch with strobe");
    io_write(iigs_pkg::OFS_KBDSTRB, 8'h00);
    io_read(iigs_pkg::OFS_KBD, d);
    check_data(d, {1'b0, v[6:0]}, "key latch after strobe clear");
    v = iigs_pkg::data_t'($urandom);
    io_write(iigs_pkg::OFS_ADB_CMD, v);
    io_read(iigs_pkg::OFS_ADB_CMD, d);
    check_data(d, v, "adb command reg");
    report_test("adb", err0);
  endtask

  task automatic test_clock_chip();
    logic [4:0] addr;
    iigs_pkg::data_t v;
    iigs_pkg::data_t d;
    iigs_pkg::data_t s0;
    int err0;
    err0 = n_errors;
    addr = 5'($urandom_range(30, 0));
    v    = iigs_pkg::data_t'($urandom);
    clock_transfer({1'b0, addr, 2'b00}, v, d);
    clock_transfer({1'b1, addr, 2'b00}, 8'h00, d);
    check_data(d, v, $sformatf("battery ram %0d", addr));
    clock_transfer(8'hfc, 8'h00, s0);  // read seconds
    pulse_cen(16 * TICKS);
    clock_transfer(8'hfc, 8'h00, d);
    check_data(d, s0 + 8'd16, "seconds counter");
    report_test("clock_chip", err0);
  endtask

  task automatic test_disk_ctrl();
    logic [4:0] mode;
    iigs_pkg::data_t d;
    int err0;
    err0 = n_errors;
    mode = 5'($urandom);
    io_read(8'hed, d);  // q6 on
    io_read(8'hef, d);  // q7 on
    io_write(8'hef, {3'b101, mode});
    io_read(8'hef, d);
    check_data(d, 8'hff, "iwm read with q7 set");
    io_read(8'hee, d);  // q7 off for a status read
    check_data(d, {3'b000, mode}, "iwm status motor off");
    io_read(8'he9, d);  // motor on but gated by disk35
    io_read(8'hee, d);
    check_data(d, {3'b000, mode}, "iwm status without disk35 bit 6");
    io_write(iigs_pkg::OFS_DISK35, 8'h40);
    io_read(8'hee, d);
    check_data(d, {3'b001, mode}, "iwm status motor on");
    io_write(8'he8, 8'h00);  // motor off
    io_read(8'hee, d);
    check_data(d, {3'b000, mode}, "iwm status after motor off");
    report_test("disk_ctrl", err0);
  endtask

  initial begin
    clk_sys   = 1'b0;
    cpu_vda   = 1'b0;
    cen       = 1'b0;
    bus_valid = 1'b0;
    bus_we    = 1'b0;
    bus_bank  = '0;
    bus_addr  = '0;
    bus_wdata = '0;
    mem_din   = '0;
    n_checks  = 0;
    n_errors  = 0;
    void'($urandom(32'hf425_831c));
    #1;
    apply_reset();
    test_reset_values();
    test_register_rw();
    test_soft_switches();
    test_adb();
    test_clock_chip();
    test_disk_ctrl();
    if (i_iigs_io.i_iigs_io_regs.i_iigs_io_chk.fail_count != 0) begin
      n_errors += int'(i_iigs_io.i_iigs_io_regs.i_iigs_io_chk.fail_count);
      $display("bus timing assertions failed %0d times",
               i_iigs_io.i_iigs_io_regs.i_iigs_io_chk.fail_count);
    end
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
